/* src.f */
rtl/lsuPkg.sv
rtl/busPkg.sv
rtl/wbIf.sv
rtl/subwordWrite.sv
rtl/subwordRead.sv
rtl/lsuFsm.sv
rtl/busTimer.sv
rtl/dataRam.sv
rtl/lsuTop.sv
sim/clockGen.sv
sim/lsuTb.sv

/* Makefile */
# Verilator simulation of the load/store unit
TOP = lsuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* sim/lsuTb.sv */
// Testbench top with reference model, stimulus, compare tasks and timeout
`timescale 1ns/1ns

module lsuTb import lsuPkg::*; import busPkg::*; ();

  localparam int Xlen          = 32;
  localparam int Lanes         = Xlen / 8;
  localparam int RamWords      = 256;
  localparam int RamBytes      = RamWords * Lanes;
  localparam int TimeoutCycles = 16;
  localparam int DoneLatency   = 3;
  localparam int RandomReqs    = 200;
  localparam int OobReqs       = 2;
  // Fill, lane, extension, random, bus error and back-pressure requests
  localparam int PlannedReqs   = RamWords + 8 + 29 + RandomReqs + 4 + 3;
  localparam int CycleLimit    = PlannedReqs * 40 + OobReqs * (TimeoutCycles + 4) + 64;

  logic            clk;
  logic            rstN;
  logic            req;
  logic            write;
  logic [2:0]      funct3;
  logic [31:0]     adr;
  logic [Xlen-1:0] writeData;
  logic [Xlen-1:0] readData;
  logic            busy;
  logic            done;
  logic            busErr;

  // Reference memory, one entry per byte
  logic [7:0]      refMem [RamBytes];

  // Expected results in request order
  logic [Xlen-1:0] expDataQ [$];
  busRespT         expStatusQ [$];
  int              expLatencyQ [$];
  int              acceptQ [$];
  int              issuedCount = 0;
  int              doneCount = 0;
  int              cycleCount = 0;

  clockGen #(.HalfPeriod(20), .ResetCycles(8)) clockGen_i (
    .clk  (clk),
    .rstN (rstN)
  );

  lsuTop #(
    .Xlen          (Xlen),
    .RamWords      (RamWords),
    .TimeoutCycles (TimeoutCycles)
  ) lsuTop_i (
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .write     (write),
    .funct3    (funct3),
    .adr       (adr),
    .writeData (writeData),
    .readData  (readData),
    .busy      (busy),
    .done      (done),
    .busErr    (busErr)
  );

  ////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkData(input string name, input logic [Xlen-1:0] got,
                           input logic [Xlen-1:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkStatus(input string name, input busRespT got, input busRespT exp);
    if (got !== exp) begin
      stopOnError($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Byte array memory, out of range gives zero and leaves memory alone
  function automatic logic [Xlen-1:0] refAccess(input logic wr, input funct3U f3,
                                                input logic [31:0] a,
                                                input logic [Xlen-1:0] wd);
    int              nBytes;
    logic [Xlen-1:0] value;
    nBytes = 1 << f3.fields.size;
    if (nBytes > Lanes) begin
      nBytes = Lanes;
    end
    value = '0;
    if (a >= 32'(RamBytes)) begin
      return '0;
    end
    if (wr) begin
      for (int i = 0; i < nBytes; i++) begin
        refMem[a + i] = wd[8*i +: 8];
      end
      return '0;
    end
    for (int i = 0; i < nBytes; i++) begin
      value[8*i +: 8] = refMem[a + i];
    end
    // Sign fill above the loaded field
    if (!f3.fields.zeroExt && value[8*nBytes-1]) begin
      for (int i = 8 * nBytes; i < Xlen; i++) begin
        value[i] = 1'b1;
      end
    end
    return value;
  endfunction

  function automatic funct3U makeFunct3(input logic zeroExt, input accessSizeT size);
    funct3U f;
    f.fields.zeroExt = zeroExt;
    f.fields.size    = size;
    return f;
  endfunction

  // Initial RAM contents, every address bit matters
  function automatic logic [Xlen-1:0] fillWord(input logic [31:0] a);
    return Xlen'((a * 32'h9E37_79B9) ^ 32'h5A5A_0F0F);
  endfunction

  ////////////////////////////////////////
  // Compare process and cycle counter
  ////////////////////////////////////////

  always @(posedge clk) begin : compareResults
    logic [Xlen-1:0] expData;
    busRespT         expStatus;
    busRespT         gotStatus;
    int              expLatency;
    int              acceptedAt;
    if (rstN) begin
      if (done) begin
        if (expDataQ.size() == 0 || acceptQ.size() == 0) begin
          stopOnError("done pulsed with no request pending");
        end
        expData    = expDataQ.pop_front();
        expStatus  = expStatusQ.pop_front();
        expLatency = expLatencyQ.pop_front();
        acceptedAt = acceptQ.pop_front();
        gotStatus  = busErr ? respTimeout : respOk;
        checkData("readData", readData, expData);
        checkStatus("busErr", gotStatus, expStatus);
        // Timeouts have no fixed latency
        if (expLatency >= 0 && cycleCount - acceptedAt != expLatency) begin
          stopOnError($sformatf("done came %0d cycles after the accepting edge, not %0d",
                                cycleCount - acceptedAt, expLatency));
        end
        doneCount++;
      end
      // Request taken at this edge
      if (req && !busy) begin
        acceptQ.push_back(cycleCount);
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      stopOnError($sformatf("Timeout after %0d cycles, the test sequence did not finish",
                            CycleLimit));
    end
  end

  ////////////////////////////////////////
  // Request tasks
  ////////////////////////////////////////

  task automatic expectResult(input logic wr, input funct3U f3, input logic [31:0] a,
                              input logic [Xlen-1:0] wd);
    logic inRange;
    inRange = a < 32'(RamBytes);
    expDataQ.push_back(refAccess(wr, f3, a, wd));
    expStatusQ.push_back(inRange ? respOk : respTimeout);
    expLatencyQ.push_back(inRange ? DoneLatency : -1);
    issuedCount++;
  endtask

  task automatic driveReq(input logic wr, input funct3U f3, input logic [31:0] a,
                          input logic [Xlen-1:0] wd);
    req       = 1'b1;
    write     = wr;
    funct3    = f3.raw;
    adr       = a;
    writeData = wd;
  endtask

  // Starts and ends on a falling edge, returns after done
  task automatic issueReq(input logic wr, input funct3U f3, input logic [31:0] a,
                          input logic [Xlen-1:0] wd);
    expectResult(wr, f3, a, wd);
    while (busy) @(negedge clk);
    driveReq(wr, f3, a, wd);
    @(negedge clk);
    req = 1'b0;
    while (doneCount < issuedCount) @(negedge clk);
  endtask

  task automatic fillRam();
    for (int w = 0; w < RamWords; w++) begin
      issueReq(1'b1, makeFunct3(1'b0, wordAcc), 32'(w * Lanes), fillWord(32'(w * Lanes)));
    end
  endtask

  // One byte lane at a time, a word load shows the other lanes
  task automatic laneStores();
    logic [Xlen-1:0] data;
    for (int lane = 0; lane < Lanes; lane++) begin
      data      = $urandom;
      data[7:0] = 8'hC0 + 8'(lane);
      issueReq(1'b1, makeFunct3(1'b0, byteAcc), 32'h40 + 32'(lane), data);
      issueReq(1'b0, makeFunct3(1'b0, wordAcc), 32'h40, '0);
    end
  endtask

  // Every load size, signed and unsigned, over one word
  task automatic loadAllSizes(input logic [31:0] base);
    for (int off = 0; off < 4; off++) begin
      issueReq(1'b0, makeFunct3(1'b0, byteAcc), base + 32'(off), '0);
      issueReq(1'b0, makeFunct3(1'b1, byteAcc), base + 32'(off), '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issueReq(1'b0, makeFunct3(1'b0, halfAcc), base + 32'(off), '0);
      issueReq(1'b0, makeFunct3(1'b1, halfAcc), base + 32'(off), '0);
    end
    issueReq(1'b0, makeFunct3(1'b0, wordAcc), base, '0);
  endtask

  task automatic extensionLoads();
    // Byte signs from low to high: negative, negative, positive, negative
    issueReq(1'b1, makeFunct3(1'b0, wordAcc), 32'h80, 32'h8F7E_91A0);
    loadAllSizes(32'h80);
    // Positive low half, negative high half, upper store bits are junk
    issueReq(1'b1, makeFunct3(1'b0, halfAcc), 32'h84, 32'hDEAD_7F01);
    issueReq(1'b1, makeFunct3(1'b0, halfAcc), 32'h86, 32'hBEEF_80FE);
    loadAllSizes(32'h84);
  endtask

  task automatic randomAccesses();
    logic            wr;
    logic            zeroExt;
    accessSizeT      size;
    logic [31:0]     a;
    logic [Xlen-1:0] data;
    for (int n = 0; n < RandomReqs; n++) begin
      wr      = 1'($urandom_range(1, 0));
      size    = accessSizeT'($urandom_range(2, 0));
      // No unsigned word load on a 32-bit core
      zeroExt = !wr && size != wordAcc && $urandom_range(1, 0) == 1;
      a       = 32'($urandom_range(RamBytes - 1, 0));
      a       = a & ~((32'd1 << size) - 32'd1);
      data    = $urandom;
      issueReq(wr, makeFunct3(zeroExt, size), a, data);
    end
  endtask

  task automatic busErrorAccesses();
    logic [31:0] oobAdr;
    // Low index bits alias word 0x40, nothing there may change
    oobAdr = 32'(RamBytes) + 32'h40;
    issueReq(1'b0, makeFunct3(1'b0, wordAcc), oobAdr, '0);
    issueReq(1'b0, makeFunct3(1'b0, wordAcc), 32'h40, '0);
    issueReq(1'b1, makeFunct3(1'b0, wordAcc), oobAdr, 32'hFFFF_FFFF);
    issueReq(1'b0, makeFunct3(1'b0, wordAcc), 32'h40, '0);
  endtask

  // Store with a stray req in the middle of its bus cycle
  task automatic backPressure();
    expectResult(1'b1, makeFunct3(1'b0, wordAcc), 32'hC0, 32'h1234_5678);
    driveReq(1'b1, makeFunct3(1'b0, wordAcc), 32'hC0, 32'h1234_5678);
    @(negedge clk);
    req = 1'b0;
    @(negedge clk);
    if (!busy) begin
      stopOnError("busy was low in the middle of a bus cycle");
    end
    // Must be ignored, the model is not updated
    driveReq(1'b1, makeFunct3(1'b0, wordAcc), 32'hC4, 32'hCAFE_F00D);
    @(negedge clk);
    req = 1'b0;
    while (doneCount < issuedCount) @(negedge clk);
    // Idle gap, a late done from the stray req would hit an empty queue
    repeat (6) @(negedge clk);
    issueReq(1'b0, makeFunct3(1'b0, wordAcc), 32'hC4, '0);
    issueReq(1'b0, makeFunct3(1'b0, wordAcc), 32'hC0, '0);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    int seedInit;
    req       = 1'b0;
    write     = 1'b0;
    funct3    = '0;
    adr       = '0;
    writeData = '0;
    seedInit  = $urandom(22657);
    wait (rstN === 1'b1);
    @(negedge clk);
    // Idle outputs after reset
    checkFlag("busy", busy, 1'b0);
    checkFlag("done", done, 1'b0);
    checkStatus("busErr", busErr ? respTimeout : respOk, respOk);
    fillRam();
    laneStores();
    extensionLoads();
    randomAccesses();
    busErrorAccesses();
    backPressure();
    repeat (4) @(negedge clk);
    if (doneCount == issuedCount && expDataQ.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stopOnError("Run ended with requests that never completed");
    end
  end

endmodule

/* sim/clockGen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ns

module clockGen #(
  parameter int HalfPeriod  = 20,
  parameter int ResetCycles = 8
) (
  output logic clk,
  output logic rstN
);

  // 40 ns period with the default half period
  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

/* rtl/lsuTop.sv */
// Load/store unit top level with a plain req/busy/done handshake
`timescale 1ns/1ns

module lsuTop import lsuPkg::*; #(
  parameter int Xlen          = 32,
  parameter int RamWords      = 256,
  parameter int TimeoutCycles = 16
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            req,
  input  logic            write,
  input  logic [2:0]      funct3,
  input  logic [31:0]     adr,
  input  logic [Xlen-1:0] writeData,
  output logic [Xlen-1:0] readData,
  output logic            busy,
  output logic            done,
  output logic            busErr
);

  funct3U            reqFunct3;
  funct3U            latchedFunct3;
  logic [2:0]        latchedAdr;
  logic [Xlen-1:0]   finalWriteData;
  logic [Xlen/8-1:0] byteMask;
  logic [Xlen-1:0]   busData;
  logic [Xlen-1:0]   loadData;
  logic              timerRun;
  logic              timerExpired;

  assign reqFunct3.raw = funct3;

  wbIf #(.Xlen(Xlen)) wbBus ();

  // Store path works on the incoming request
  subwordWrite #(.Xlen(Xlen)) subwordWrite_i (
    .funct3         (reqFunct3),
    .adr            (adr[2:0]),
    .writeData      (writeData),
    .finalWriteData (finalWriteData),
    .byteMask       (byteMask)
  );

  // Load path works on the latched request and the ack-time bus data
  subwordRead #(.Xlen(Xlen)) subwordRead_i (
    .funct3   (latchedFunct3),
    .adr      (latchedAdr),
    .busData  (busData),
    .loadData (loadData)
  );

  lsuFsm #(.Xlen(Xlen)) lsuFsm_i (
    .clk            (clk),
    .rstN           (rstN),
    .req            (req),
    .write          (write),
    .funct3         (reqFunct3),
    .adr            (adr),
    .finalWriteData (finalWriteData),
    .byteMask       (byteMask),
    .latchedFunct3  (latchedFunct3),
    .latchedAdr     (latchedAdr),
    .busData        (busData),
    .loadData       (loadData),
    .readData       (readData),
    .busy           (busy),
    .done           (done),
    .busErr         (busErr),
    .timerRun       (timerRun),
    .timerExpired   (timerExpired),
    .wb             (wbBus.master)
  );

  busTimer #(.TimeoutCycles(TimeoutCycles)) busTimer_i (
    .clk     (clk),
    .rstN    (rstN),
    .run     (timerRun),
    .expired (timerExpired)
  );

  dataRam #(.Xlen(Xlen), .RamWords(RamWords)) dataRam_i (
    .clk  (clk),
    .rstN (rstN),
    .wb   (wbBus.slave)
  );

endmodule

/* rtl/dataRam.sv */
// Wishbone classic slave RAM with byte lane writes and range decode
`timescale 1ns/1ns

module dataRam import busPkg::*; #(
  parameter int Xlen     = 32,
  parameter int RamWords = 256
) (
  input logic clk,
  input logic rstN,
  wbIf.slave  wb
);

  localparam int Lanes   = Xlen / 8;
  localparam int OffBits = offsetBits(Xlen);
  localparam int WadBits = AdrWidth - OffBits;
  localparam int IdxBits = (RamWords > 1) ? $clog2(RamWords) : 1;

  logic [Xlen-1:0]    mem [RamWords];
  logic [WadBits-1:0] wordAdr;
  logic [IdxBits-1:0] idx;
  logic               inRange;
  logic               hit;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign wordAdr = wb.adr[AdrWidth-1:OffBits];
  assign idx     = wordAdr[IdxBits-1:0];
  assign inRange = (wordAdr < WadBits'(RamWords));

  // New strobe only, the !ack term keeps ack to one cycle
  assign hit = wb.cyc && wb.stb && !wb.ack && inRange;

  // Out of range never acks, the master times out
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wb.ack <= 1'b0;
    end else begin
      wb.ack <= hit;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (hit) begin
      if (wb.we) begin
        // Only the enabled lanes change
        for (int lane = 0; lane < Lanes; lane++) begin
          if (wb.sel[lane]) begin
            mem[idx][lane*8 +: 8] <= wb.datW[lane*8 +: 8];
          end
        end
      end else begin
        wb.datR <= mem[idx];
      end
    end
  end

endmodule

/* rtl/busTimer.sv */
// Bus wait cycle counter that flags a timeout
`timescale 1ns/1ns

module busTimer #(
  parameter int TimeoutCycles = 16
) (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  output logic expired
);

  localparam int CntBits = $clog2(TimeoutCycles + 1);

  logic [CntBits-1:0] count;

  assign expired = (count == CntBits'(TimeoutCycles));

  // Clears between cycles, saturates at the limit
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;
    end else if (!expired) begin
      count <= count + 1'b1;
    end
  end

  // Timeout can only start inside a running bus cycle
  expiredInRun: assert property (@(posedge clk) disable iff (!rstN)
    $rose(expired) |-> run);

endmodule

/* rtl/lsuFsm.sv */
// Load/store request FSM that runs one Wishbone classic cycle per request
`timescale 1ns/1ns

module lsuFsm import lsuPkg::*; import busPkg::*; #(
  parameter int Xlen = 32
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                req,
  input  logic                write,
  input  funct3U              funct3,
  input  logic [AdrWidth-1:0] adr,
  input  logic [Xlen-1:0]     finalWriteData,
  input  logic [Xlen/8-1:0]   byteMask,
  output funct3U              latchedFunct3,
  output logic [2:0]          latchedAdr,
  output logic [Xlen-1:0]     busData,
  input  logic [Xlen-1:0]     loadData,
  output logic [Xlen-1:0]     readData,
  output logic                busy,
  output logic                done,
  output logic                busErr,
  output logic                timerRun,
  input  logic                timerExpired,
  wbIf.master                 wb
);

  localparam int Lanes = Xlen / 8;

  typedef enum logic [1:0] {
    idle   = 2'b00,
    bus    = 2'b01,
    finish = 2'b10
  } stateT;

  stateT               state;
  stateT               nextState;
  logic                accept;
  logic                cycleEnd;
  logic                writeQ;
  funct3U              funct3Q;
  logic [AdrWidth-1:0] adrQ;
  logic [Xlen-1:0]     dataQ;
  logic [Lanes-1:0]    maskQ;
  busRespT             resp;
  logic [2:0]          alignMask;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Finish doubles as idle, so a new request can start right after done
  assign busy     = (state == bus);
  assign done     = (state == finish);
  assign accept   = req && !busy;
  assign cycleEnd = busy && (wb.ack || timerExpired);
  assign timerRun = busy;

  always_comb begin
    nextState = state;
    case (state)
      idle, finish: nextState = req ? bus : idle;
      bus:          if (wb.ack || timerExpired) nextState = finish;
      default:      nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  // Response of the last cycle, ack wins over a late timeout
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resp <= respOk;
    end else if (cycleEnd) begin
      resp <= wb.ack ? respOk : respTimeout;
    end
  end

  assign busErr = done && (resp == respTimeout);

  ////////////////////////////////////////
  // Request and result registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      writeQ  <= write;
      funct3Q <= funct3;
      adrQ    <= adr;
      dataQ   <= finalWriteData;
      maskQ   <= byteMask;
    end
  end

  // Writes and timeouts hand back zero
  always_ff @(posedge clk) begin
    if (cycleEnd) begin
      readData <= (wb.ack && !writeQ) ? loadData : '0;
    end
  end

  assign latchedFunct3 = funct3Q;
  assign latchedAdr    = adrQ[2:0];
  assign busData       = wb.datR;

  // Bus drive, held steady for the whole cycle
  assign wb.cyc  = busy;
  assign wb.stb  = busy;
  assign wb.we   = writeQ;
  assign wb.adr  = adrQ;
  assign wb.datW = dataQ;
  assign wb.sel  = maskQ;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Low address bits that must be zero for the access size
  always_comb begin
    case (funct3.fields.size)
      byteAcc: alignMask = 3'b000;
      halfAcc: alignMask = 3'b001;
      wordAcc: alignMask = 3'b011;
      default: alignMask = (Xlen == 64) ? 3'b111 : 3'b011;
    endcase
  end

  reqAligned: assert property (@(posedge clk) disable iff (!rstN)
    accept |-> ((adr[2:0] & alignMask) == 3'b000));

  ackInCycle: assert property (@(posedge clk) disable iff (!rstN)
    wb.ack |-> (wb.cyc && wb.stb));

endmodule

/* rtl/subwordRead.sv */
// Load byte extraction with sign or zero extension
`timescale 1ns/1ns

module subwordRead import lsuPkg::*; #(
  parameter int Xlen = 32
) (
  input  funct3U          funct3,
  input  logic [2:0]      adr,
  input  logic [Xlen-1:0] busData,
  output logic [Xlen-1:0] loadData
);

  localparam int Lanes   = Xlen / 8;
  localparam int OffBits = $clog2(Lanes);

  accessSizeT      effSize;
  logic [Xlen-1:0] shifted;
  logic [Xlen-1:0] keepMask;
  logic            signBit;

  // ld on a 32-bit bus reads a word
  always_comb begin
    effSize = funct3.fields.size;
    if (Xlen == 32 && effSize == dblAcc) begin
      effSize = wordAcc;
    end
  end

  // Addressed bytes down to bit 0
  assign shifted = busData >> {adr[OffBits-1:0], 3'b000};

  // Bits kept from the bus and the sign bit of that field
  always_comb begin
    case (effSize)
      byteAcc: begin
        keepMask = Xlen'(8'hFF);
        signBit  = shifted[7];
      end
      halfAcc: begin
        keepMask = Xlen'(16'hFFFF);
        signBit  = shifted[15];
      end
      wordAcc: begin
        keepMask = Xlen'(32'hFFFF_FFFF);
        signBit  = shifted[31];
      end
      default: begin
        // Full width, nothing left to extend
        keepMask = '1;
        signBit  = 1'b0;
      end
    endcase
  end

  // Upper bits are ones only for a signed load of a negative value
  assign loadData = (shifted & keepMask)
                  | ((!funct3.fields.zeroExt && signBit) ? ~keepMask : '0);

endmodule

/* rtl/subwordWrite.sv */
// Store byte mask generation and store data replication
`timescale 1ns/1ns

module subwordWrite import lsuPkg::*; #(
  parameter int Xlen = 32
) (
  input  funct3U            funct3,
  input  logic [2:0]        adr,
  input  logic [Xlen-1:0]   writeData,
  output logic [Xlen-1:0]   finalWriteData,
  output logic [Xlen/8-1:0] byteMask
);

  localparam int Lanes   = Xlen / 8;
  localparam int OffBits = $clog2(Lanes);

  accessSizeT       effSize;
  logic [Lanes-1:0] baseMask;

  // No doubleword lanes on a 32-bit bus, so sd falls back to a word
  always_comb begin
    effSize = funct3.fields.size;
    if (Xlen == 32 && effSize == dblAcc) begin
      effSize = wordAcc;
    end
  end

  // Lanes covered by the access, before the offset shift
  always_comb begin
    case (effSize)
      byteAcc: baseMask = Lanes'(1);
      halfAcc: baseMask = Lanes'(3);
      wordAcc: baseMask = Lanes'(15);
      default: baseMask = '1;
    endcase
  end

  assign byteMask = baseMask << adr[OffBits-1:0];

  // Copy the low bytes into every lane, the mask picks the right one
  always_comb begin
    case (effSize)
      byteAcc: finalWriteData = {Lanes{writeData[7:0]}};
      halfAcc: finalWriteData = {(Lanes / 2){writeData[15:0]}};
      wordAcc: finalWriteData = {(Lanes / 4){writeData[31:0]}};
      default: finalWriteData = writeData;
    endcase
  end

endmodule

/* rtl/wbIf.sv */
// Wishbone classic bus interface with master and slave modports
`timescale 1ns/1ns

interface wbIf import busPkg::*; #(
  parameter int Xlen = 32
) ();

  localparam int Lanes = Xlen / 8;

  // Master side
  logic                cyc;
  logic                stb;
  logic                we;
  logic [AdrWidth-1:0] adr;
  logic [Xlen-1:0]     datW;
  logic [Lanes-1:0]    sel;

  // Slave side
  logic [Xlen-1:0]     datR;
  logic                ack;

  // Load/store state machine
  modport master (
    output cyc, stb, we, adr, datW, sel,
    input  datR, ack
  );

  // Memory or peripheral
  modport slave (
    input  cyc, stb, we, adr, datW, sel,
    output datR, ack
  );

endinterface

/* rtl/busPkg.sv */
// Wishbone width helpers and the bus response code
package busPkg;

  // Byte address width on the data bus
  localparam int AdrWidth = 32;

  // Number of byte offset bits below the word address
  function automatic int offsetBits(input int xlen);
    return $clog2(xlen / 8);
  endfunction

  // How a bus cycle ended
  typedef enum logic [1:0] {
    respOk      = 2'b00,
    respTimeout = 2'b01
  } busRespT;

endpackage

/* rtl/lsuPkg.sv */
// Access size codes and the funct3 union for the load/store data path
package lsuPkg;

  ////////////////////////////////////////
  // Access size
  ////////////////////////////////////////

  // Low two bits of the RISC-V load/store funct3
  typedef enum logic [1:0] {
    byteAcc = 2'b00,
    halfAcc = 2'b01,
    wordAcc = 2'b10,
    dblAcc  = 2'b11
  } accessSizeT;

  ////////////////////////////////////////
  // funct3 decode
  ////////////////////////////////////////

  // Field view, bit 2 marks the unsigned loads (lbu, lhu, lwu)
  typedef struct packed {
    logic       zeroExt;
    accessSizeT size;
  } funct3FieldsT;

  // Same three bits, seen raw or split into fields
  typedef union packed {
    logic [2:0]   raw;
    funct3FieldsT fields;
  } funct3U;

endpackage
